/* alu/alu.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"

module alu #(
	parameter DATA_LEN = `XLEN
) (
	input exu_pkg::word_t src1,
	input exu_pkg::word_t src2,
	input exu_pkg::alu_op_t alu_control,
	output exu_pkg::word_t result
);

	import exu_pkg::*;

	localparam NR_OPS = 11;

	logic [DATA_LEN-1:0] sum;
	logic [DATA_LEN:0] sub_ext;
	logic [DATA_LEN-1:0] diff;
	logic lt_signed;
	logic lt_unsigned;
	logic [4:0] shamt;
	logic [DATA_LEN-1:0] sll_res;
	logic [DATA_LEN-1:0] srl_res;
	logic [DATA_LEN-1:0] sra_res;
	logic [DATA_LEN-1:0] result_tmp;

	assign sum = src1 + src2;

	// subtract as a + ~b + 1, one bit wider for the carry out
	assign sub_ext = {1'b0, src1} + {1'b0, ~src2} + {{DATA_LEN{1'b0}}, 1'b1};
	assign diff = sub_ext[DATA_LEN-1:0];

	// no carry out means a borrow, so src1 < src2 unsigned
	assign lt_unsigned = ~sub_ext[DATA_LEN];

	// signs differ: the negative one is smaller
	// signs equal: difference cannot overflow, its sign decides
	assign lt_signed = (src1[DATA_LEN-1] ^ src2[DATA_LEN-1]) ? src1[DATA_LEN-1]
		: diff[DATA_LEN-1];

	// rv32i only looks at the low five bits
	assign shamt = src2[4:0];
	assign sll_res = src1 << shamt;
	assign srl_res = src1 >> shamt;
	assign sra_res = $signed(src1) >>> shamt;

	// unknown codes fall through to zero
	mux_key_default #(
		.NR_KEY(NR_OPS),
		.KEY_LEN(`ALU_OP_W),
		.DATA_LEN(DATA_LEN)
	) u_alu_mux (
		.out(result_tmp),
		.key(alu_control),
		.default_out({DATA_LEN{1'b0}}),
		.lut({
			`ALU_ADD, sum,
			`ALU_SUB, diff,
			`ALU_SLL, sll_res,
			`ALU_SLT, {{(DATA_LEN-1){1'b0}}, lt_signed},
			`ALU_SLTU, {{(DATA_LEN-1){1'b0}}, lt_unsigned},
			`ALU_XOR, src1 ^ src2,
			`ALU_SRL, srl_res,
			`ALU_SRA, sra_res,
			`ALU_OR, src1 | src2,
			`ALU_AND, src1 & src2,
			`ALU_PASS2, src2
		})
	);

	assign result = result_tmp;

endmodule

/* alu/alu_decode.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"

module alu_decode (
	input logic inst_valid,
	input logic [31:0] inst,
	output exu_pkg::reg_idx_t rs1_idx,
	output exu_pkg::reg_idx_t rs2_idx,
	output exu_pkg::reg_idx_t rd_idx,
	output exu_pkg::alu_op_t alu_op,
	output exu_pkg::word_t imm,
	output logic use_imm,
	output logic use_pc_zero,
	output logic wr_en
);

	import exu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t i_imm;
	word_t u_imm;
	logic legal;

	// fixed rv32i field positions
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd_idx = inst[11:7];
	assign rs1_idx = inst[19:15];
	assign rs2_idx = inst[24:20];

	// sign-extended I-type immediate
	assign i_imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
	// U-type, upper 20 bits, low 12 zero
	assign u_imm = {inst[31:12], 12'b0};

	always_comb begin
		legal = 1'b0;
		alu_op = `ALU_ADD;
		imm = i_imm;
		use_imm = 1'b0;
		use_pc_zero = 1'b0;
		case (opcode)
			`OPC_OP: begin
				// reg-reg, funct7 must be base or the alt pattern where allowed
				case (funct3)
					`F3_ADD_SUB: begin
						legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
						alu_op = (funct7 == `F7_ALT) ? `ALU_SUB : `ALU_ADD;
					end
					`F3_SRL_SRA: begin
						legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
						alu_op = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
					end
					`F3_SLL: begin
						legal = (funct7 == `F7_BASE);
						alu_op = `ALU_SLL;
					end
					`F3_SLT: begin
						legal = (funct7 == `F7_BASE);
						alu_op = `ALU_SLT;
					end
					`F3_SLTU: begin
						legal = (funct7 == `F7_BASE);
						alu_op = `ALU_SLTU;
					end
					`F3_XOR: begin
						legal = (funct7 == `F7_BASE);
						alu_op = `ALU_XOR;
					end
					`F3_OR: begin
						legal = (funct7 == `F7_BASE);
						alu_op = `ALU_OR;
					end
					default: begin
						legal = (funct7 == `F7_BASE);
						alu_op = `ALU_AND;
					end
				endcase
			end
			`OPC_OP_IMM: begin
				use_imm = 1'b1;
				legal = 1'b1;
				// funct3 000 is always addi, there is no immediate subtract
				case (funct3)
					`F3_ADD_SUB: alu_op = `ALU_ADD;
					`F3_SLT: alu_op = `ALU_SLT;
					`F3_SLTU: alu_op = `ALU_SLTU;
					`F3_XOR: alu_op = `ALU_XOR;
					`F3_OR: alu_op = `ALU_OR;
					`F3_AND: alu_op = `ALU_AND;
					`F3_SLL: begin
						legal = (funct7 == `F7_BASE);
						alu_op = `ALU_SLL;
					end
					default: begin
						// srli / srai, bit 30 picks arithmetic
						legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
						alu_op = funct7[5] ? `ALU_SRA : `ALU_SRL;
					end
				endcase
			end
			`OPC_LUI: begin
				// 0 + (imm << 12)
				legal = 1'b1;
				imm = u_imm;
				use_imm = 1'b1;
				use_pc_zero = 1'b1;
				alu_op = `ALU_ADD;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	// x0 destination and illegal encodings never reach writeback
	assign wr_en = inst_valid && legal && (rd_idx != '0);

endmodule

/* bench/exu_checker.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"

module exu_checker (
	input logic clk,
	input logic arst_n,
	input logic wb_valid,
	input logic [`REG_IDX_W-1:0] wb_rd,
	input logic [`XLEN-1:0] wb_data,
	input logic exp_en,
	input int exp_row,
	input logic exp_valid,
	input logic [`REG_IDX_W-1:0] exp_rd,
	input logic [`XLEN-1:0] exp_data,
	output int err_count,
	output int check_count
);

	// expectations of the row issued one cycle earlier
	logic en_d = 1'b0;
	int row_d = 0;
	logic valid_d = 1'b0;
	logic [`REG_IDX_W-1:0] rd_d = '0;
	logic [`XLEN-1:0] data_d = '0;
	int errors = 0;
	int checks = 0;

	assign err_count = errors;
	assign check_count = checks;

	// row issued in cycle n shows up at the writeback ports in cycle n+1
	always @(posedge clk) begin
		en_d <= exp_en;
		row_d <= exp_row;
		valid_d <= exp_valid;
		rd_d <= exp_rd;
		data_d <= exp_data;
	end

	// compare mid-cycle, writeback outputs settled by then
	always @(negedge clk) begin
		if (!arst_n) begin
			checks = checks + 1;
			if (wb_valid !== 1'b0) begin
				errors = errors + 1;
				$display("[FAIL] %0t ns: wb_valid high during reset", $time);
			end
		end else if (en_d) begin
			checks = checks + 1;
			if (wb_valid !== valid_d) begin
				errors = errors + 1;
				$display("[FAIL] %0t ns: row %0d wb_valid is %b, expected %b",
					$time, row_d, wb_valid, valid_d);
			end else if (valid_d) begin
				// rd and data only mean something with a valid writeback
				if (wb_rd !== rd_d) begin
					errors = errors + 1;
					$display("[FAIL] %0t ns: row %0d wb_rd is %0d, expected %0d",
						$time, row_d, wb_rd, rd_d);
				end
				if (wb_data !== data_d) begin
					errors = errors + 1;
					$display("[FAIL] %0t ns: row %0d wb_data is %h, expected %h",
						$time, row_d, wb_data, data_d);
				end
			end
		end
	end

endmodule

/* bench/exu_tb.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"

module exu_tb;

	localparam MAX_ROWS = 64;
	localparam NR_RANDOM = 8;

	logic clk;
	logic arst_n;
	logic inst_valid;
	logic [31:0] inst;
	logic wb_valid;
	logic [`REG_IDX_W-1:0] wb_rd;
	logic [`XLEN-1:0] wb_data;

	// expectations handed to the checker with each row
	logic exp_en;
	int exp_row;
	logic exp_valid;
	logic [`REG_IDX_W-1:0] exp_rd;
	logic [`XLEN-1:0] exp_data;
	int err_count;
	int check_count;

	// stimulus table, one row per cycle
	logic [31:0] tbl_inst [MAX_ROWS];
	logic tbl_valid [MAX_ROWS];
	logic tbl_exp_valid [MAX_ROWS];
	logic [`REG_IDX_W-1:0] tbl_exp_rd [MAX_ROWS];
	logic [`XLEN-1:0] tbl_exp_data [MAX_ROWS];
	int nr_rows;
	logic table_ready;
	int timeout_limit;
	int cycles;

	// reference register state for the random rows
	logic [`XLEN-1:0] model [32];
	integer seed;

	exu_top u_exu_top (
		.clk(clk),
		.arst_n(arst_n),
		.inst_valid(inst_valid),
		.inst(inst),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	exu_checker u_exu_checker (
		.clk(clk),
		.arst_n(arst_n),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.exp_en(exp_en),
		.exp_row(exp_row),
		.exp_valid(exp_valid),
		.exp_rd(exp_rd),
		.exp_data(exp_data),
		.err_count(err_count),
		.check_count(check_count)
	);

	// instruction encoders, rv32i field layout
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
		input int rd);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], `OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] enc_u(input int imm20, input int rd);
		return {imm20[19:0], rd[4:0], `OPC_LUI};
	endfunction

	task automatic add_row(input logic [31:0] row_inst, input int row_valid, input int ev,
		input int erd, input logic [31:0] edata);
		tbl_inst[nr_rows] = row_inst;
		tbl_valid[nr_rows] = row_valid[0];
		tbl_exp_valid[nr_rows] = ev[0];
		tbl_exp_rd[nr_rows] = erd[4:0];
		tbl_exp_data[nr_rows] = edata;
		nr_rows = nr_rows + 1;
	endtask

	// random addi chains on x20..x23 only, the fixed rows never touch them
	task automatic add_random_rows(input int count);
		int r;
		int rd;
		int rs1;
		int imm;
		logic [31:0] sum;
		for (int k = 0; k < count; k++) begin
			r = $random(seed);
			rd = 20 + (r & 3);
			rs1 = ((r >> 2) & 1) ? 20 + ((r >> 3) & 3) : 0;
			// top 12 bits, sign kept by the arithmetic shift
			imm = r >>> 20;
			sum = model[rs1] + imm;
			model[rd] = sum;
			add_row(enc_i(imm, rs1, `F3_ADD_SUB, rd), 1, 1, rd, sum);
		end
	endtask

	task automatic build_table();
		nr_rows = 0;
		// inst, valid, exp valid, exp rd, exp data
		add_row(32'h0, 0, 0, 0, 32'h0);
		add_row(32'h0, 0, 0, 0, 32'h0);
		add_row(enc_i(5, 0, `F3_ADD_SUB, 1), 1, 1, 1, 32'd5);
		add_row(enc_i(-3, 0, `F3_ADD_SUB, 2), 1, 1, 2, 32'hFFFFFFFD);
		add_row(enc_u('h12345, 3), 1, 1, 3, 32'h12345000);
		add_row(enc_r(`F7_BASE, 2, 1, `F3_ADD_SUB, 4), 1, 1, 4, 32'd2);
		add_row(enc_r(`F7_ALT, 1, 2, `F3_ADD_SUB, 5), 1, 1, 5, 32'hFFFFFFF8);
		// 0 - 5 wraps
		add_row(enc_r(`F7_ALT, 1, 0, `F3_ADD_SUB, 6), 1, 1, 6, 32'hFFFFFFFB);
		add_row(enc_r(`F7_BASE, 2, 1, `F3_XOR, 7), 1, 1, 7, 32'hFFFFFFF8);
		add_row(enc_r(`F7_BASE, 2, 1, `F3_OR, 8), 1, 1, 8, 32'hFFFFFFFD);
		add_row(enc_r(`F7_BASE, 3, 2, `F3_AND, 9), 1, 1, 9, 32'h12345000);
		// -3 vs 5, signs differ
		add_row(enc_r(`F7_BASE, 1, 2, `F3_SLT, 10), 1, 1, 10, 32'd1);
		add_row(enc_r(`F7_BASE, 1, 2, `F3_SLTU, 11), 1, 1, 11, 32'd0);
		// shift amount 33, low five bits give 1
		add_row(enc_i(33, 0, `F3_ADD_SUB, 12), 1, 1, 12, 32'd33);
		add_row(enc_r(`F7_BASE, 12, 1, `F3_SLL, 13), 1, 1, 13, 32'hA);
		add_row(enc_r(`F7_BASE, 12, 2, `F3_SRL_SRA, 14), 1, 1, 14, 32'h7FFFFFFE);
		add_row(enc_r(`F7_ALT, 12, 2, `F3_SRL_SRA, 15), 1, 1, 15, 32'hFFFFFFFE);
		// back-to-back dependency chain
		add_row(enc_i(100, 0, `F3_ADD_SUB, 16), 1, 1, 16, 32'd100);
		add_row(enc_i(7, 16, `F3_ADD_SUB, 16), 1, 1, 16, 32'd107);
		add_row(enc_r(`F7_BASE, 16, 16, `F3_ADD_SUB, 17), 1, 1, 17, 32'd214);
		add_row(enc_r(`F7_ALT, 16, 17, `F3_ADD_SUB, 18), 1, 1, 18, 32'd107);
		// no writeback: rd x0, bad funct7, idle slot, load opcode
		add_row(enc_i(9, 1, `F3_ADD_SUB, 0), 1, 0, 0, 32'h0);
		add_row(enc_r(7'b0000001, 1, 1, `F3_ADD_SUB, 19), 1, 0, 0, 32'h0);
		add_row(enc_i(1, 0, `F3_ADD_SUB, 20), 0, 0, 0, 32'h0);
		add_row(32'h0000A983, 1, 0, 0, 32'h0);
		// x0 still reads zero
		add_row(enc_r(`F7_BASE, 0, 0, `F3_OR, 19), 1, 1, 19, 32'h0);
		// 5 vs -2, signed and unsigned disagree
		add_row(enc_i(-2, 1, `F3_SLT, 24), 1, 1, 24, 32'd0);
		add_row(enc_i(-1, 1, `F3_SLTU, 25), 1, 1, 25, 32'd1);
		add_row(enc_i(-1, 2, `F3_XOR, 26), 1, 1, 26, 32'd2);
		add_row(enc_i('h401, 2, `F3_SRL_SRA, 27), 1, 1, 27, 32'hFFFFFFFE);
		add_row(enc_i(12, 2, `F3_SRL_SRA, 28), 1, 1, 28, 32'h000FFFFF);
		add_row(enc_i(31, 1, `F3_SLL, 29), 1, 1, 29, 32'h80000000);
		add_row(enc_i('h7F4, 1, `F3_OR, 30), 1, 1, 30, 32'h000007F5);
		add_row(enc_u('hFFFFF, 31), 1, 1, 31, 32'hFFFFF000);
		// slli with bit 30 set is not an encoding
		add_row(enc_i('h401, 1, `F3_SLL, 31), 1, 0, 0, 32'h0);
		add_random_rows(NR_RANDOM);
		add_row(32'h0, 0, 0, 0, 32'h0);
		add_row(32'h0, 0, 0, 0, 32'h0);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// hang guard, sized from the table length
	initial begin
		cycles = 0;
		wait (table_ready);
		while (cycles < timeout_limit) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("ERROR: the run hung and did not finish within %0d cycles", timeout_limit);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		exp_en = 1'b0;
		exp_row = 0;
		exp_valid = 1'b0;
		exp_rd = '0;
		exp_data = '0;
		table_ready = 1'b0;
		seed = 32'h635cbb3f;
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
		end
		build_table();
		timeout_limit = nr_rows + 20;
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
		for (int i = 0; i < nr_rows; i++) begin
			@(posedge clk);
			#1;
			inst_valid = tbl_valid[i];
			inst = tbl_inst[i];
			exp_en = 1'b1;
			exp_row = i;
			exp_valid = tbl_exp_valid[i];
			exp_rd = tbl_exp_rd[i];
			exp_data = tbl_exp_data[i];
		end
		@(posedge clk);
		#1;
		inst_valid = 1'b0;
		exp_en = 1'b0;
		// last row is compared at this falling edge
		@(negedge clk);
		#1;
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* common/exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// datapath and register index widths
`define XLEN 32
`define REG_IDX_W 5
`define ALU_OP_W 4

// rv32i major opcodes handled by this unit
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI 7'b0110111

// funct3 field values
`define F3_ADD_SUB 3'b000
`define F3_SLL 3'b001
`define F3_SLT 3'b010
`define F3_SLTU 3'b011
`define F3_XOR 3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR 3'b110
`define F3_AND 3'b111

// funct7 patterns, alt one selects sub / sra
`define F7_BASE 7'b0000000
`define F7_ALT 7'b0100000

// alu operation codes
`define ALU_ADD 4'b0000
`define ALU_SUB 4'b0001
`define ALU_SLL 4'b0010
`define ALU_SLT 4'b0011
`define ALU_SLTU 4'b0100
`define ALU_XOR 4'b0101
`define ALU_SRL 4'b0110
`define ALU_SRA 4'b0111
`define ALU_OR 4'b1000
`define ALU_AND 4'b1001
`define ALU_PASS2 4'b1010

`endif

/* common/exu_pkg.sv */
`include "exu_defs.svh"

package exu_pkg;

	// one data word of the datapath
	typedef logic [`XLEN-1:0] word_t;

	// architectural register index, x0..x31
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

	// alu operation code, see ALU_* macros
	typedef logic [`ALU_OP_W-1:0] alu_op_t;

	// where a source operand comes from
	typedef enum logic {
		// register file read port
		BYP_RF = 1'b0,
		// pending writeback register
		BYP_WB = 1'b1
	} byp_src_t;

endpackage

/* exu.f */
+incdir+common
common/exu_pkg.sv
logic/mux_key_default.sv
alu/alu.sv
alu/alu_decode.sv
logic/reg_file.sv
logic/writeback_bypass.sv
logic/exu_top.sv
bench/exu_checker.sv
bench/exu_tb.sv

/* logic/exu_top.sv */
`timescale 1ns/1ns

module exu_top (
	input logic clk,
	input logic arst_n,
	input logic inst_valid,
	input logic [31:0] inst,
	output logic wb_valid,
	output exu_pkg::reg_idx_t wb_rd,
	output exu_pkg::word_t wb_data
);

	import exu_pkg::*;

	reg_idx_t rs1_idx;
	reg_idx_t rs2_idx;
	reg_idx_t rd_idx;
	alu_op_t alu_op;
	word_t imm;
	logic use_imm;
	logic use_pc_zero;
	logic wr_en;
	word_t rf_rdata1;
	word_t rf_rdata2;
	word_t op_a;
	word_t op_b;
	word_t alu_src1;
	word_t alu_src2;
	word_t alu_result;

	alu_decode u_alu_decode (
		.inst_valid(inst_valid),
		.inst(inst),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rd_idx(rd_idx),
		.alu_op(alu_op),
		.imm(imm),
		.use_imm(use_imm),
		.use_pc_zero(use_pc_zero),
		.wr_en(wr_en)
	);

	// written from the writeback stage, commits one edge after it
	reg_file u_reg_file (
		.clk(clk),
		.arst_n(arst_n),
		.raddr1(rs1_idx),
		.raddr2(rs2_idx),
		.rdata1(rf_rdata1),
		.rdata2(rf_rdata2),
		.we(wb_valid),
		.waddr(wb_rd),
		.wdata(wb_data)
	);

	writeback_bypass u_writeback_bypass (
		.clk(clk),
		.arst_n(arst_n),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rf_rdata1(rf_rdata1),
		.rf_rdata2(rf_rdata2),
		.alu_result(alu_result),
		.rd_idx(rd_idx),
		.wr_en(wr_en),
		.op_a(op_a),
		.op_b(op_b),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	// lui zeroes operand a, immediates replace operand b
	assign alu_src1 = use_pc_zero ? '0 : op_a;
	assign alu_src2 = use_imm ? imm : op_b;

	alu u_alu (
		.src1(alu_src1),
		.src2(alu_src2),
		.alu_control(alu_op),
		.result(alu_result)
	);

endmodule

/* logic/mux_key_default.sv */
`timescale 1ns/1ns

module mux_key_default #(
	parameter NR_KEY = 2,
	parameter KEY_LEN = 1,
	parameter DATA_LEN = 1
) (
	output logic [DATA_LEN-1:0] out,
	input logic [KEY_LEN-1:0] key,
	input logic [DATA_LEN-1:0] default_out,
	input logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut
);

	localparam PAIR_LEN = KEY_LEN + DATA_LEN;

	logic [KEY_LEN-1:0] key_list [NR_KEY];
	logic [DATA_LEN-1:0] data_list [NR_KEY];
	logic dup_key;

	// pair i sits at bits [PAIR_LEN*(i+1)-1 : PAIR_LEN*i]
	// key in the upper part, data in the lower part
	for (genvar i = 0; i < NR_KEY; i++) begin : g_pair
		assign data_list[i] = lut[PAIR_LEN*i +: DATA_LEN];
		assign key_list[i] = lut[PAIR_LEN*i + DATA_LEN +: KEY_LEN];
	end

	// default unless some key hits
	always_comb begin
		out = default_out;
		for (int i = 0; i < NR_KEY; i++) begin
			if (key == key_list[i]) begin
				out = data_list[i];
			end
		end
	end

	// table keys must be distinct, otherwise the lowest pair silently loses
	always_comb begin
		dup_key = 1'b0;
		for (int i = 0; i < NR_KEY; i++) begin
			for (int j = i + 1; j < NR_KEY; j++) begin
				if (key_list[i] == key_list[j]) begin
					dup_key = 1'b1;
				end
			end
		end
		assert (!dup_key) else $error("mux_key_default: duplicate key in table");
	end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ns
`include "exu_defs.svh"

module reg_file (
	input logic clk,
	input logic arst_n,
	input exu_pkg::reg_idx_t raddr1,
	input exu_pkg::reg_idx_t raddr2,
	output exu_pkg::word_t rdata1,
	output exu_pkg::word_t rdata2,
	input logic we,
	input exu_pkg::reg_idx_t waddr,
	input exu_pkg::word_t wdata
);

	import exu_pkg::*;

	localparam NR_REGS = 1 << `REG_IDX_W;

	word_t regs [NR_REGS];

	// architectural state, cleared on reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NR_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 reads as zero regardless of contents
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// decode already drops rd == x0, so none should arrive here
	a_no_x0_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		we |-> (waddr != '0)
	) else $error("reg_file: write to x0");

endmodule

/* logic/writeback_bypass.sv */
`timescale 1ns/1ns

module writeback_bypass (
	input logic clk,
	input logic arst_n,
	input exu_pkg::reg_idx_t rs1_idx,
	input exu_pkg::reg_idx_t rs2_idx,
	input exu_pkg::word_t rf_rdata1,
	input exu_pkg::word_t rf_rdata2,
	input exu_pkg::word_t alu_result,
	input exu_pkg::reg_idx_t rd_idx,
	input logic wr_en,
	output exu_pkg::word_t op_a,
	output exu_pkg::word_t op_b,
	output logic wb_valid,
	output exu_pkg::reg_idx_t wb_rd,
	output exu_pkg::word_t wb_data
);

	import exu_pkg::*;

	byp_src_t sel_a;
	byp_src_t sel_b;

	// pending writeback not yet in the register file
	// wb_rd is never x0 while valid, so x0 never forwards
	assign sel_a = (wb_valid && (wb_rd == rs1_idx)) ? BYP_WB : BYP_RF;
	assign sel_b = (wb_valid && (wb_rd == rs2_idx)) ? BYP_WB : BYP_RF;

	always_comb begin
		case (sel_a)
			BYP_WB: op_a = wb_data;
			default: op_a = rf_rdata1;
		endcase
	end

	always_comb begin
		case (sel_b)
			BYP_WB: op_b = wb_data;
			default: op_b = rf_rdata2;
		endcase
	end

	// valid bit is the only control state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= wr_en;
		end
	end

	// payload only loads for a real write
	always_ff @(posedge clk) begin
		if (wr_en) begin
			wb_rd <= rd_idx;
			wb_data <= alu_result;
		end
	end

	a_wb_rd_nonzero: assert property (
		@(posedge clk) disable iff (!arst_n)
		wb_valid |-> (wb_rd != '0)
	) else $error("writeback_bypass: valid writeback to x0");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f exu.f --top-module exu_tb -o exu_sim
./obj_dir/exu_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
